//--- design/mipsPkg.sv
package mipsPkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  regAddr_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;
        typedef logic [4:0]  aluOp_t;
        typedef logic [2:0]  branchKind_t;
        typedef logic [1:0]  memWidth_t;

        ////////////////////////////////////////////////////////////////////////////
        // opcode field
        ////////////////////////////////////////////////////////////////////////////
        localparam opcode_t OP_RTYPE  = 6'b000000;
        localparam opcode_t OP_REGIMM = 6'b000001;  // bltz only
        localparam opcode_t OP_J      = 6'b000010;
        localparam opcode_t OP_JAL    = 6'b000011;
        localparam opcode_t OP_BEQ    = 6'b000100;
        localparam opcode_t OP_BNE    = 6'b000101;
        localparam opcode_t OP_BLEZ   = 6'b000110;
        localparam opcode_t OP_BGTZ   = 6'b000111;
        localparam opcode_t OP_ADDI   = 6'b001000;
        localparam opcode_t OP_ADDIU  = 6'b001001;
        localparam opcode_t OP_SLTI   = 6'b001010;
        localparam opcode_t OP_SLTIU  = 6'b001011;
        localparam opcode_t OP_ANDI   = 6'b001100;
        localparam opcode_t OP_ORI    = 6'b001101;
        localparam opcode_t OP_XORI   = 6'b001110;
        localparam opcode_t OP_LUI    = 6'b001111;
        localparam opcode_t OP_LB     = 6'b100000;
        localparam opcode_t OP_LH     = 6'b100001;
        localparam opcode_t OP_LW     = 6'b100011;
        localparam opcode_t OP_SB     = 6'b101000;
        localparam opcode_t OP_SH     = 6'b101001;
        localparam opcode_t OP_SW     = 6'b101011;

        // R-type funct field
        localparam funct_t FN_SLL  = 6'b000000;
        localparam funct_t FN_SRL  = 6'b000010;
        localparam funct_t FN_ADD  = 6'b100000;
        localparam funct_t FN_ADDU = 6'b100001;
        localparam funct_t FN_SUB  = 6'b100010;
        localparam funct_t FN_SUBU = 6'b100011;
        localparam funct_t FN_AND  = 6'b100100;
        localparam funct_t FN_OR   = 6'b100101;
        localparam funct_t FN_XOR  = 6'b100110;
        localparam funct_t FN_NOR  = 6'b100111;
        localparam funct_t FN_SLT  = 6'b101010;
        localparam funct_t FN_SLTU = 6'b101011;

        ////////////////////////////////////////////////////////////////////////////
        // controller to datapath codes
        ////////////////////////////////////////////////////////////////////////////
        localparam aluOp_t ALU_FUNCT = 5'd0;    // decode funct
        localparam aluOp_t ALU_AND   = 5'd1;
        localparam aluOp_t ALU_ADD   = 5'd2;
        localparam aluOp_t ALU_OR    = 5'd3;
        localparam aluOp_t ALU_XOR   = 5'd4;
        localparam aluOp_t ALU_SLT   = 5'd5;
        localparam aluOp_t ALU_SUB   = 5'd6;
        localparam aluOp_t ALU_SLTU  = 5'd11;
        localparam aluOp_t ALU_LUI   = 5'd12;

        localparam branchKind_t BR_NONE = 3'b000;
        localparam branchKind_t BR_EQ   = 3'b001;
        localparam branchKind_t BR_NE   = 3'b010;
        localparam branchKind_t BR_JUMP = 3'b011;
        localparam branchKind_t BR_LTZ  = 3'b100;
        localparam branchKind_t BR_GTZ  = 3'b101;
        localparam branchKind_t BR_LEZ  = 3'b110;

        localparam memWidth_t MEM_BYTE = 2'd0;
        localparam memWidth_t MEM_HALF = 2'd1;
        localparam memWidth_t MEM_WORD = 2'd2;

        localparam int IMEM_WORDS  = 256;
        localparam int DMEM_BYTES  = 1024;
        localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
        localparam int DMEM_ADDR_W = $clog2(DMEM_BYTES);

        localparam regAddr_t RA_REG = 5'd31;    // jal link register

endpackage

//--- design/controller.sv
`timescale 1ns/1ns

module controller (
        input  mipsPkg::opcode_t     opcode,
        input  mipsPkg::funct_t      funct,
        output logic                 regDst,
        output logic                 aluSrc,
        output logic                 memToReg,
        output logic                 regWrite,
        output logic                 memRead,
        output logic                 memWrite,
        output mipsPkg::branchKind_t branchJump,
        output mipsPkg::aluOp_t      aluOp,
        output mipsPkg::memWidth_t   memWidth
);
        import mipsPkg::*;

        logic functKnown;

        always_comb begin
                case (funct)
                        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                        FN_AND, FN_OR, FN_XOR, FN_NOR,
                        FN_SLT, FN_SLTU, FN_SLL, FN_SRL: functKnown = 1'b1;
                        default:                         functKnown = 1'b0;
                endcase
        end

        // access width, only looked at by loads and stores
        always_comb begin
                case (opcode)
                        OP_LB, OP_SB: memWidth = MEM_BYTE;
                        OP_LH, OP_SH: memWidth = MEM_HALF;
                        default:      memWidth = MEM_WORD;
                endcase
        end

        always_comb begin
                // undefined opcodes keep these: no write, no access, pc+4
                regDst     = 1'b0;
                aluSrc     = 1'b0;
                memToReg   = 1'b0;
                regWrite   = 1'b0;
                memRead    = 1'b0;
                memWrite   = 1'b0;
                branchJump = BR_NONE;
                aluOp      = ALU_FUNCT;
                case (opcode)
                        OP_RTYPE: begin
                                memToReg = 1'b1;
                                regWrite = functKnown;  // drop unknown funct
                        end
                        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                        OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                                regDst   = 1'b1;        // write rt
                                aluSrc   = 1'b1;
                                memToReg = 1'b1;
                                regWrite = 1'b1;
                                case (opcode)
                                        OP_SLTI:  aluOp = ALU_SLT;
                                        OP_SLTIU: aluOp = ALU_SLTU;
                                        OP_ANDI:  aluOp = ALU_AND;
                                        OP_ORI:   aluOp = ALU_OR;
                                        OP_XORI:  aluOp = ALU_XOR;
                                        OP_LUI:   aluOp = ALU_LUI;
                                        default:  aluOp = ALU_ADD;
                                endcase
                        end
                        OP_LB, OP_LH, OP_LW: begin
                                regDst   = 1'b1;
                                aluSrc   = 1'b1;
                                regWrite = 1'b1;
                                memRead  = 1'b1;
                                aluOp    = ALU_ADD;     // base + offset
                        end
                        OP_SB, OP_SH, OP_SW: begin
                                aluSrc   = 1'b1;
                                memWrite = 1'b1;
                                aluOp    = ALU_ADD;
                        end
                        OP_BEQ: begin
                                branchJump = BR_EQ;
                                aluOp      = ALU_SUB;
                        end
                        OP_BNE: begin
                                branchJump = BR_NE;
                                aluOp      = ALU_SUB;
                        end
                        OP_REGIMM: begin
                                branchJump = BR_LTZ;
                                aluOp      = ALU_SUB;
                        end
                        OP_BGTZ: begin
                                branchJump = BR_GTZ;
                                aluOp      = ALU_SUB;
                        end
                        OP_BLEZ: begin
                                branchJump = BR_LEZ;
                                aluOp      = ALU_SUB;
                        end
                        OP_J: branchJump = BR_JUMP;
                        OP_JAL: begin
                                branchJump = BR_JUMP;
                                regWrite   = 1'b1;      // link into ra
                        end
                        default: ;
                endcase
        end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
        input  mipsPkg::aluOp_t aluOp,
        input  mipsPkg::funct_t funct,
        input  logic [4:0]      shamt,
        input  mipsPkg::word_t  a,
        input  mipsPkg::word_t  b,
        output mipsPkg::word_t  result,
        output logic            zero
);
        import mipsPkg::*;

        word_t sum;
        word_t diff;
        word_t lessSigned;
        word_t lessUnsigned;

        // no overflow trap, so add and addu share one adder
        assign sum          = a + b;
        assign diff         = a - b;
        assign lessSigned   = {31'd0, $signed(a) < $signed(b)};
        assign lessUnsigned = {31'd0, a < b};

        always_comb begin
                if (aluOp == ALU_FUNCT) begin
                        case (funct)
                                FN_ADD, FN_ADDU: result = sum;
                                FN_SUB, FN_SUBU: result = diff;
                                FN_AND:          result = a & b;
                                FN_OR:           result = a | b;
                                FN_XOR:          result = a ^ b;
                                FN_NOR:          result = ~(a | b);
                                FN_SLT:          result = lessSigned;
                                FN_SLTU:         result = lessUnsigned;
                                FN_SLL:          result = b << shamt;
                                FN_SRL:          result = b >> shamt;  // logical
                                default:         result = '0;
                        endcase
                end else begin
                        case (aluOp)
                                ALU_ADD:  result = sum;
                                ALU_SUB:  result = diff;
                                ALU_AND:  result = a & b;
                                ALU_OR:   result = a | b;
                                ALU_XOR:  result = a ^ b;
                                ALU_SLT:  result = lessSigned;
                                ALU_SLTU: result = lessUnsigned;
                                ALU_LUI:  result = {b[15:0], 16'd0};
                                default:  result = '0;
                        endcase
                end
        end

        assign zero = (result == '0);   // beq/bne compare

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ns

module registerFile (
        input  logic              clk,
        input  logic              rstN,
        input  logic              we,
        input  mipsPkg::regAddr_t readAddrA,
        input  mipsPkg::regAddr_t readAddrB,
        input  mipsPkg::regAddr_t writeAddr,
        input  mipsPkg::word_t    writeData,
        output mipsPkg::word_t    readDataA,
        output mipsPkg::word_t    readDataB
);
        import mipsPkg::*;

        word_t regs [32];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && writeAddr != '0) begin
                        regs[writeAddr] <= writeData;   // $zero stays zero
                end
        end

        assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
        assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ns

module dataMemory (
        input  logic               clk,
        input  logic               writeEn,
        input  logic               readEn,
        input  mipsPkg::memWidth_t width,
        input  mipsPkg::word_t     address,
        input  mipsPkg::word_t     writeData,
        output mipsPkg::word_t     readData
);
        import mipsPkg::*;

        logic [7:0] mem [DMEM_BYTES];

        // byte lanes wrap inside the array
        logic [DMEM_ADDR_W-1:0] addr0;
        logic [DMEM_ADDR_W-1:0] addr1;
        logic [DMEM_ADDR_W-1:0] addr2;
        logic [DMEM_ADDR_W-1:0] addr3;

        assign addr0 = address[DMEM_ADDR_W-1:0];
        assign addr1 = addr0 + DMEM_ADDR_W'(1);
        assign addr2 = addr0 + DMEM_ADDR_W'(2);
        assign addr3 = addr0 + DMEM_ADDR_W'(3);

        ////////////////////////////////////////////////////////////////////////////
        // little-endian stores
        ////////////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (writeEn) begin
                        mem[addr0] <= writeData[7:0];
                        if (width != MEM_BYTE) begin
                                mem[addr1] <= writeData[15:8];
                        end
                        if (width == MEM_WORD) begin
                                mem[addr2] <= writeData[23:16];
                                mem[addr3] <= writeData[31:24];
                        end
                end
        end

        // loads sign-extend byte and half
        always_comb begin
                if (!readEn) begin
                        readData = '0;
                end else begin
                        case (width)
                                MEM_BYTE: readData = {{24{mem[addr0][7]}}, mem[addr0]};
                                MEM_HALF: readData = {{16{mem[addr1][7]}}, mem[addr1], mem[addr0]};
                                default:  readData = {mem[addr3], mem[addr2], mem[addr1], mem[addr0]};
                        endcase
                end
        end

endmodule

//--- design/instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory (
        input  logic           clk,
        input  logic           loadEn,
        input  mipsPkg::word_t loadAddr,
        input  mipsPkg::word_t loadData,
        input  mipsPkg::word_t fetchAddr,
        output mipsPkg::word_t instruction
);
        import mipsPkg::*;

        word_t mem [IMEM_WORDS];

        always_ff @(posedge clk) begin
                if (loadEn) begin
                        mem[loadAddr[IMEM_ADDR_W-1:0]] <= loadData;     // loadAddr is a word index
                end
        end

        assign instruction = mem[fetchAddr[IMEM_ADDR_W+1:2]];  // byte pc to word

endmodule

//--- design/pcUnit.sv
`timescale 1ns/1ns

module pcUnit (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic                 run,
        input  mipsPkg::branchKind_t branchJump,
        input  mipsPkg::word_t       rsData,
        input  logic                 zero,
        input  mipsPkg::word_t       immediate,
        input  logic [25:0]          jumpTarget,
        output mipsPkg::word_t       pc,
        output mipsPkg::word_t       pcPlus4,
        output mipsPkg::word_t       nextPc
);
        import mipsPkg::*;

        logic  rsNeg;
        logic  rsZero;
        logic  taken;
        word_t branchTarget;

        assign rsNeg        = rsData[31];
        assign rsZero       = (rsData == '0);
        assign pcPlus4      = pc + 32'd4;
        assign branchTarget = pcPlus4 + {immediate[29:0], 2'b00};

        always_comb begin
                case (branchJump)
                        BR_EQ:   taken = zero;
                        BR_NE:   taken = !zero;
                        BR_LTZ:  taken = rsNeg;
                        BR_GTZ:  taken = !rsNeg && !rsZero;
                        BR_LEZ:  taken = rsNeg || rsZero;
                        default: taken = 1'b0;
                endcase
        end

        always_comb begin
                if (branchJump == BR_JUMP) begin
                        nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};  // pseudo-direct
                end else if (taken) begin
                        nextPc = branchTarget;
                end else begin
                        nextPc = pcPlus4;
                end
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (run) begin
                        pc <= nextPc;   // hold while stopped
                end
        end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ns

module mipsCore (
        input  logic              clk,
        input  logic              rstN,
        input  logic              run,
        input  logic              loadEn,
        input  mipsPkg::word_t    loadAddr,
        input  mipsPkg::word_t    loadData,
        output mipsPkg::word_t    pc,
        output mipsPkg::word_t    nextPc,
        output logic              commitWe,
        output mipsPkg::regAddr_t commitAddr,
        output mipsPkg::word_t    commitData
);
        import mipsPkg::*;

        word_t       instruction;
        word_t       pcPlus4;
        logic        regDst;
        logic        aluSrc;
        logic        memToReg;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        branchKind_t branchJump;
        aluOp_t      aluOp;
        memWidth_t   memWidth;
        word_t       rsData;
        word_t       rtData;
        word_t       signImm;
        word_t       aluB;
        word_t       aluResult;
        logic        zero;
        word_t       loadResult;
        logic        isJal;
        logic        zeroExt;

        instructionMemory u_instructionMemory (
                .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
                .fetchAddr(pc), .instruction(instruction)
        );

        controller u_controller (
                .opcode(instruction[31:26]), .funct(instruction[5:0]),
                .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
                .memRead(memRead), .memWrite(memWrite), .branchJump(branchJump),
                .aluOp(aluOp), .memWidth(memWidth)
        );

        ////////////////////////////////////////////////////////////////////////////
        // operand and write-back selection
        ////////////////////////////////////////////////////////////////////////////
        assign isJal   = (instruction[31:26] == OP_JAL);
        assign zeroExt = (instruction[31:26] == OP_ANDI) || (instruction[31:26] == OP_ORI)
                         || (instruction[31:26] == OP_XORI);   // logical imm
        assign signImm = {{16{instruction[15]}}, instruction[15:0]};
        assign aluB    = !aluSrc ? rtData : zeroExt ? {16'd0, instruction[15:0]} : signImm;

        assign commitAddr = isJal ? RA_REG : regDst ? instruction[20:16] : instruction[15:11];
        assign commitData = isJal ? pcPlus4 : memToReg ? aluResult : loadResult;
        assign commitWe   = run && regWrite;

        registerFile u_registerFile (
                .clk(clk), .rstN(rstN), .we(commitWe),
                .readAddrA(instruction[25:21]), .readAddrB(instruction[20:16]),
                .writeAddr(commitAddr), .writeData(commitData),
                .readDataA(rsData), .readDataB(rtData)
        );

        alu u_alu (
                .aluOp(aluOp), .funct(instruction[5:0]), .shamt(instruction[10:6]),
                .a(rsData), .b(aluB), .result(aluResult), .zero(zero)
        );

        dataMemory u_dataMemory (
                .clk(clk), .writeEn(run && memWrite), .readEn(memRead), .width(memWidth),
                .address(aluResult), .writeData(rtData), .readData(loadResult)
        );

        pcUnit u_pcUnit (
                .clk(clk), .rstN(rstN), .run(run), .branchJump(branchJump),
                .rsData(rsData), .zero(zero), .immediate(signImm),
                .jumpTarget(instruction[25:0]), .pc(pc), .pcPlus4(pcPlus4), .nextPc(nextPc)
        );

endmodule

//--- dv/programTable.svh
// one row per executed instruction in execution order
// columns are pc, instruction word, write enable, destination, write data and next pc
word_t    stepPc[$];
word_t    stepInstr[$];
logic     stepWe[$];
regAddr_t stepAddr[$];
word_t    stepData[$];
word_t    stepNext[$];
word_t    curPc;
int       stallAt;

function automatic word_t rType(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
endfunction

function automatic word_t jType(opcode_t op, logic [25:0] index);
        return {op, index};
endfunction

function automatic void record(word_t instr, logic we, regAddr_t addr, word_t data,
                               word_t next);
        stepPc.push_back(curPc);
        stepInstr.push_back(instr);
        stepWe.push_back(we);
        stepAddr.push_back(addr);
        stepData.push_back(data);
        stepNext.push_back(next);
        curPc = next;   // follow the taken path
endfunction

function automatic void straight(word_t instr, logic we, regAddr_t addr, word_t data);
        record(instr, we, addr, data, curPc + 32'd4);
endfunction

function automatic void branchTo(word_t instr, word_t next);
        record(instr, 1'b0, 5'd0, 32'd0, next);
endfunction

function automatic void buildProgram(word_t a, word_t b);
        word_t target;
        word_t link;
        curPc = 32'd0;
        ////////////////////////////////////////////////////////////////////////////
        // arithmetic and logic with r1 = 5 and r2 = -3
        ////////////////////////////////////////////////////////////////////////////
        straight(iType(OP_ADDIU, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5);
        straight(iType(OP_ADDIU, 5'd0, 5'd2, 16'hFFFD), 1'b1, 5'd2, 32'hFFFF_FFFD);
        straight(rType(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'd2);
        straight(rType(FN_SUB, 5'd1, 5'd2, 5'd4, 5'd0), 1'b1, 5'd4, 32'd8);
        straight(rType(FN_AND, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1, 5'd5, 32'd5);
        straight(rType(FN_OR, 5'd1, 5'd2, 5'd6, 5'd0), 1'b1, 5'd6, 32'hFFFF_FFFD);
        straight(rType(FN_XOR, 5'd1, 5'd2, 5'd7, 5'd0), 1'b1, 5'd7, 32'hFFFF_FFF8);
        straight(rType(FN_NOR, 5'd1, 5'd2, 5'd8, 5'd0), 1'b1, 5'd8, 32'd2);
        straight(rType(FN_SLT, 5'd2, 5'd1, 5'd9, 5'd0), 1'b1, 5'd9, 32'd1);
        straight(rType(FN_SLTU, 5'd2, 5'd1, 5'd10, 5'd0), 1'b1, 5'd10, 32'd0);
        straight(rType(FN_SLL, 5'd0, 5'd1, 5'd11, 5'd4), 1'b1, 5'd11, 32'h50);
        straight(rType(FN_SRL, 5'd0, 5'd2, 5'd12, 5'd28), 1'b1, 5'd12, 32'hF);
        straight(rType(FN_ADDU, 5'd2, 5'd2, 5'd13, 5'd0), 1'b1, 5'd13, 32'hFFFF_FFFA);
        straight(rType(FN_SUBU, 5'd2, 5'd1, 5'd14, 5'd0), 1'b1, 5'd14, 32'hFFFF_FFF8);
        straight(iType(OP_ADDIU, 5'd1, 5'd0, 16'd7), 1'b1, 5'd0, 32'd12);    // write to $zero
        straight(rType(FN_OR, 5'd0, 5'd1, 5'd15, 5'd0), 1'b1, 5'd15, 32'd5);  // $zero still 0
        // zero- versus sign-extended immediates
        straight(iType(OP_LUI, 5'd0, 5'd16, 16'h8765), 1'b1, 5'd16, 32'h8765_0000);
        straight(iType(OP_ORI, 5'd16, 5'd16, 16'h4321), 1'b1, 5'd16, 32'h8765_4321);
        straight(iType(OP_ANDI, 5'd2, 5'd17, 16'h8F0F), 1'b1, 5'd17, 32'h0000_8F0D);
        straight(iType(OP_XORI, 5'd2, 5'd18, 16'h80F0), 1'b1, 5'd18, 32'hFFFF_7F0D);
        straight(iType(OP_ORI, 5'd0, 5'd19, 16'h9000), 1'b1, 5'd19, 32'h0000_9000);
        straight(iType(OP_SLTI, 5'd2, 5'd20, 16'hFFFE), 1'b1, 5'd20, 32'd1);
        straight(iType(OP_SLTIU, 5'd2, 5'd20, 16'd4), 1'b1, 5'd20, 32'd0);
        straight(iType(OP_ADDI, 5'd0, 5'd21, 16'h0100), 1'b1, 5'd21, 32'h100);
        ////////////////////////////////////////////////////////////////////////////
        // stores then loads around byte 256
        ////////////////////////////////////////////////////////////////////////////
        straight(iType(OP_SW, 5'd21, 5'd16, 16'd0), 1'b0, 5'd0, 32'd0);
        straight(iType(OP_SW, 5'd21, 5'd16, 16'd4), 1'b0, 5'd0, 32'd0);
        straight(iType(OP_SB, 5'd21, 5'd1, 16'd5), 1'b0, 5'd0, 32'd0);
        straight(iType(OP_SH, 5'd21, 5'd2, 16'd6), 1'b0, 5'd0, 32'd0);
        straight(iType(OP_LW, 5'd21, 5'd22, 16'd0), 1'b1, 5'd22, 32'h8765_4321);
        straight(iType(OP_LW, 5'd21, 5'd23, 16'd4), 1'b1, 5'd23, 32'hFFFD_0521);
        straight(iType(OP_LB, 5'd21, 5'd24, 16'd3), 1'b1, 5'd24, 32'hFFFF_FF87);
        straight(iType(OP_LB, 5'd21, 5'd24, 16'd5), 1'b1, 5'd24, 32'd5);
        straight(iType(OP_LH, 5'd21, 5'd25, 16'd2), 1'b1, 5'd25, 32'hFFFF_8765);
        straight(iType(OP_LH, 5'd21, 5'd25, 16'd6), 1'b1, 5'd25, 32'hFFFF_FFFD);
        straight(iType(OP_LH, 5'd21, 5'd26, 16'd0), 1'b1, 5'd26, 32'h0000_4321);
        // taken branches skip one word
        branchTo(iType(OP_BEQ, 5'd1, 5'd1, 16'd1), curPc + 32'd8);
        branchTo(iType(OP_BNE, 5'd1, 5'd1, 16'd5), curPc + 32'd4);
        branchTo(iType(OP_BNE, 5'd1, 5'd2, 16'd1), curPc + 32'd8);
        branchTo(iType(OP_BEQ, 5'd1, 5'd2, 16'd4), curPc + 32'd4);
        branchTo(iType(OP_BGTZ, 5'd1, 5'd0, 16'd1), curPc + 32'd8);
        branchTo(iType(OP_BGTZ, 5'd2, 5'd0, 16'd4), curPc + 32'd4);
        branchTo(iType(OP_BGTZ, 5'd0, 5'd0, 16'd4), curPc + 32'd4);
        branchTo(iType(OP_BLEZ, 5'd2, 5'd0, 16'd1), curPc + 32'd8);
        branchTo(iType(OP_BLEZ, 5'd0, 5'd0, 16'd1), curPc + 32'd8);
        branchTo(iType(OP_BLEZ, 5'd1, 5'd0, 16'd4), curPc + 32'd4);
        branchTo(iType(OP_REGIMM, 5'd2, 5'd0, 16'd1), curPc + 32'd8);  // bltz
        branchTo(iType(OP_REGIMM, 5'd1, 5'd0, 16'd4), curPc + 32'd4);
        ////////////////////////////////////////////////////////////////////////////
        // random operands with run dropped before the first one
        ////////////////////////////////////////////////////////////////////////////
        stallAt = stepPc.size();
        straight(iType(OP_LUI, 5'd0, 5'd27, a[31:16]), 1'b1, 5'd27, {a[31:16], 16'd0});
        straight(iType(OP_ORI, 5'd27, 5'd27, a[15:0]), 1'b1, 5'd27, a);
        straight(iType(OP_LUI, 5'd0, 5'd28, b[31:16]), 1'b1, 5'd28, {b[31:16], 16'd0});
        straight(iType(OP_ORI, 5'd28, 5'd28, b[15:0]), 1'b1, 5'd28, b);
        straight(rType(FN_ADDU, 5'd27, 5'd28, 5'd29, 5'd0), 1'b1, 5'd29, a + b);
        straight(rType(FN_SUBU, 5'd27, 5'd28, 5'd30, 5'd0), 1'b1, 5'd30, a - b);
        straight(rType(FN_XOR, 5'd27, 5'd28, 5'd3, 5'd0), 1'b1, 5'd3, a ^ b);
        // signs differ means the negative one is less
        straight(rType(FN_SLT, 5'd27, 5'd28, 5'd4, 5'd0), 1'b1, 5'd4,
                 (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b});
        straight(rType(FN_SLTU, 5'd27, 5'd28, 5'd5, 5'd0), 1'b1, 5'd5, {31'd0, a < b});
        // forward jumps where jal links pc+4 into ra
        target = curPc + 32'd12;
        branchTo(jType(OP_J, target[27:2]), target);
        target = curPc + 32'd20;
        link   = curPc + 32'd4;
        record(jType(OP_JAL, target[27:2]), 1'b1, RA_REG, link, target);
        straight(rType(FN_ADDU, RA_REG, 5'd0, 5'd6, 5'd0), 1'b1, 5'd6, link);
endfunction

//--- dv/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb;
        import mipsPkg::*;

        localparam int CLK_PERIOD   = 40;
        localparam int RESET_CYCLES = 8;
        localparam int STALL_CYCLES = 3;

        logic     clk;
        logic     rstN;
        logic     run;
        logic     loadEn;
        word_t    loadAddr;
        word_t    loadData;
        word_t    pc;
        word_t    nextPc;
        logic     commitWe;
        regAddr_t commitAddr;
        word_t    commitData;

        integer   seed;
        word_t    randA;
        word_t    randB;
        int       errors;
        int       checks;
        logic     tableReady;

        `include "programTable.svh"

        mipsCore u_mipsCore (
                .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn),
                .loadAddr(loadAddr), .loadData(loadData), .pc(pc), .nextPc(nextPc),
                .commitWe(commitWe), .commitAddr(commitAddr), .commitData(commitData)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        task automatic checkValue(string name, word_t expected, word_t actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
                end
        endtask

        task automatic verifyStep(int i);
                string tag;
                tag = $sformatf("step %0d pc 0x%08h", i, stepPc[i]);
                checkValue({tag, " pc"}, stepPc[i], pc);
                checkValue({tag, " commitWe"}, {31'd0, stepWe[i]}, {31'd0, commitWe});
                if (stepWe[i]) begin    // addr and data only mean something on a write
                        checkValue({tag, " commitAddr"}, {27'd0, stepAddr[i]},
                                   {27'd0, commitAddr});
                        checkValue({tag, " commitData"}, stepData[i], commitData);
                end
                checkValue({tag, " nextPc"}, stepNext[i], nextPc);
        endtask

        // run low for a few cycles while pc stays put
        task automatic holdStopped(word_t frozenPc);
                run = 1'b0;
                repeat (STALL_CYCLES) begin
                        @(negedge clk);
                        checkValue("stall pc", frozenPc, pc);
                        checkValue("stall commitWe", 32'd0, {31'd0, commitWe});
                        @(posedge clk);
                        #2;
                end
                run = 1'b1;
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////////////////////////////
        initial begin
                clk        = 1'b0;
                rstN       = 1'b0;
                run        = 1'b0;
                loadEn     = 1'b0;
                loadAddr   = '0;
                loadData   = '0;
                errors     = 0;
                checks     = 0;
                tableReady = 1'b0;
                seed       = 57373;
                randA      = $random(seed);
                randB      = $random(seed);
                buildProgram(randA, randB);
                tableReady = 1'b1;

                repeat (RESET_CYCLES) @(posedge clk);
                #2;
                rstN = 1'b1;

                for (int i = 0; i < stepPc.size(); i++) begin
                        loadEn   = 1'b1;
                        loadAddr = stepPc[i] >> 2;      // word index
                        loadData = stepInstr[i];
                        @(posedge clk);
                        #2;
                end
                loadEn = 1'b0;

                @(negedge clk);
                checkValue("idle pc", 32'd0, pc);
                checkValue("idle commitWe", 32'd0, {31'd0, commitWe});
                @(posedge clk);
                #2;
                run = 1'b1;

                for (int i = 0; i < stepPc.size(); i++) begin
                        if (i == stallAt) begin
                                holdStopped(stepPc[i]);
                        end
                        @(negedge clk);         // outputs settled before the edge
                        verifyStep(i);
                        @(posedge clk);
                        #2;
                end
                run = 1'b0;

                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

        // watchdog sized from load plus execute length
        initial begin
                wait (tableReady);
                repeat (2 * stepPc.size() + RESET_CYCLES + 40) @(posedge clk);
                $display("simulation timed out before all steps were checked");
                $display("checks %0d errors %0d", checks, errors);
                $display("Regression failed");
                $finish;
        end

endmodule

//--- mipsCore.f
+incdir+dv
design/mipsPkg.sv
design/controller.sv
design/alu.sv
design/registerFile.sv
design/dataMemory.sv
design/instructionMemory.sv
design/pcUnit.sv
design/mipsCore.sv
dv/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f mipsCore.f --top-module mipsCoreTb -o mipsCoreSim \
        && ./obj_dir/mipsCoreSim | tee sim.log \
        || { echo "build or simulation error"; exit 1; }
grep -q "^Regression passed$" sim.log && exit 0 || exit 1
